// ==== src.f ====
+incdir+include
logic/pixel_pkg.sv
logic/command_pkg.sv
logic/frame_crop.sv
logic/bayer_demosaic.sv
logic/exposure_meter.sv
logic/capture_writer.sv
logic/image_buffer.sv
logic/command_decoder.sv
logic/camera_top.sv
bench/clock_gen.sv
bench/camera_tb.sv

// ==== bench/camera_tb.sv ====
// Camera front end testbench
// Directed capture, readback and metering tests against a frame model
`timescale 1ns/1ps
`include "camera_defines.svh"

module camera_tb;

    import pixel_pkg::*;
    import command_pkg::*;

    localparam int FRAME_COLS     = 20;
    localparam int FRAME_ROWS     = 20;
    localparam int LINE_GAP       = 4;
    localparam int FRAME_GAP      = 8;
    localparam int CELL_COLS      = `CAM_CROP_WIDTH / 2;
    localparam int DROP_BITS      = `CAM_PIXEL_BITS - 8; // 10-bit sample to 8-bit channel
    localparam int TIMEOUT_CYCLES = 8 * FRAME_ROWS * (FRAME_COLS + LINE_GAP) + 2000;

    logic       clock_spi_in;
    logic       mipi_byte_reset_n;
    raw_pixel_t raw_pixel;
    opcode_e    op_code;
    logic       op_code_valid;
    logic       operand_valid;
    logic [1:0] operand_count;
    response_t  response;
    logic       response_valid;

    logic [31:0]                lfsr_state;
    logic [`CAM_PIXEL_BITS-1:0] frame_samples [FRAME_ROWS][FRAME_COLS];
    rgb_pixel_t                 model_pixels [`CAM_RGB_PIXELS]; // Expected buffer contents
    meter_t                     model_meter;
    int                         cycle_count = 0;

    clock_gen clock_source (.clock_o(clock_spi_in), .reset_n_o(mipi_byte_reset_n));

    camera_top uut (
        .clock_spi_in,
        .mipi_byte_reset_n,
        .raw_pixel_i      (raw_pixel),
        .op_code_i        (op_code),
        .op_code_valid_i  (op_code_valid),
        .operand_valid_i  (operand_valid),
        .operand_count_i  (operand_count),
        .response_o       (response),
        .response_valid_o (response_valid)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Run stopped at %0t ns", $time);
    endtask

    always @(posedge clock_spi_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure("Timeout: the tests did not finish within the cycle limit");
        end
    end

    task automatic check_response(input response_t actual, input response_t expected,
                                  input string name);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch at %0t ns: %s got 8'h%02h expected 8'h%02h",
                                        $time, name, actual, expected));
        end
    endtask

    task automatic check_meter(input meter_t actual, input meter_t expected, input string name);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch at %0t ns: %s got 24'h%06h expected 24'h%06h",
                                        $time, name, actual, expected));
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic random_sample(output logic [`CAM_PIXEL_BITS-1:0] value);
        value = '0;
        for (int b = 0; b < `CAM_PIXEL_BITS; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[`CAM_PIXEL_BITS-2:0], lfsr_state[0]};
        end
    endtask

    // New random frame plus its expected pixels and averages
    task automatic build_frame();
        logic [`CAM_PIXEL_BITS-1:0] sample;
        rgb_pixel_t                 pixel;
        int                         top;
        int                         left;
        int                         green_avg;
        int                         red_sum;
        int                         green_sum;
        int                         blue_sum;
        red_sum   = 0;
        green_sum = 0;
        blue_sum  = 0;
        for (int r = 0; r < FRAME_ROWS; r++) begin
            for (int c = 0; c < FRAME_COLS; c++) begin
                random_sample(sample);
                frame_samples[r][c] = sample;
            end
        end
        for (int i = 0; i < `CAM_RGB_PIXELS; i++) begin
            top       = `CAM_CROP_Y_START + 2 * (i / CELL_COLS); // RGGB cell, red top-left
            left      = `CAM_CROP_X_START + 2 * (i % CELL_COLS);
            green_avg = (int'(frame_samples[top][left + 1]) +
                         int'(frame_samples[top + 1][left])) / 2;
            pixel.red   = 8'(frame_samples[top][left] >> DROP_BITS);
            pixel.green = 8'(green_avg >> DROP_BITS);
            pixel.blue  = 8'(frame_samples[top + 1][left + 1] >> DROP_BITS);
            model_pixels[i] = pixel;
            red_sum   += pixel.red;
            green_sum += pixel.green;
            blue_sum  += pixel.blue;
        end
        model_meter.red   = 8'(red_sum >> `CAM_METER_SHIFT);
        model_meter.green = 8'(green_sum >> `CAM_METER_SHIFT);
        model_meter.blue  = 8'(blue_sum >> `CAM_METER_SHIFT);
    endtask

    task automatic drive_raw(input logic frame_valid, input logic line_valid,
                             input logic [`CAM_PIXEL_BITS-1:0] sample);
        @(negedge clock_spi_in);
        raw_pixel.frame_valid = frame_valid;
        raw_pixel.line_valid  = line_valid;
        raw_pixel.sample      = sample;
    endtask

    task automatic send_frame();
        for (int r = 0; r < FRAME_ROWS; r++) begin
            for (int c = 0; c < FRAME_COLS; c++) begin
                drive_raw(1'b1, 1'b1, frame_samples[r][c]);
            end
            repeat (LINE_GAP) drive_raw(1'b1, 1'b0, '0);
        end
        repeat (FRAME_GAP) drive_raw(1'b0, 1'b0, '0);
    endtask

    // One opcode cycle, response expected on the next
    task automatic issue_command(input opcode_e code, input logic [1:0] count,
                                 output response_t value);
        @(negedge clock_spi_in);
        op_code       = code;
        operand_count = count;
        op_code_valid = 1'b1;
        @(negedge clock_spi_in);
        if (!response_valid) begin
            stop_with_failure($sformatf("No response valid after opcode %s", code.name()));
        end
        value         = response;
        op_code_valid = 1'b0;
        @(negedge clock_spi_in);
        if (response_valid) begin
            stop_with_failure("Response valid stayed high after the opcode ended");
        end
    endtask

    task automatic read_meter(output meter_t value);
        response_t channel_value;
        issue_command(OP_METER, 2'd0, channel_value);
        value.red = channel_value;
        issue_command(OP_METER, 2'd1, channel_value);
        value.green = channel_value;
        issue_command(OP_METER, 2'd2, channel_value);
        value.blue = channel_value;
    endtask

    task automatic expect_status(input response_t expected);
        response_t value;
        issue_command(OP_STATUS, 2'd0, value);
        check_response(value, expected, "response_o (capture status)");
    endtask

    // Operand strobes under one held OP_READ, checked against the model from pixel 0
    task automatic read_bytes(input int count);
        rgb_pixel_t expected;
        response_t  expected_byte;
        @(negedge clock_spi_in);
        op_code       = OP_READ;
        op_code_valid = 1'b1;
        for (int k = 0; k < count; k++) begin
            expected = model_pixels[(k / 3) % `CAM_RGB_PIXELS];
            case (k % 3)
                0:       expected_byte = expected.red;
                1:       expected_byte = expected.green;
                default: expected_byte = expected.blue;
            endcase
            @(negedge clock_spi_in);
            operand_valid = 1'b1;
            @(negedge clock_spi_in);
            if (!response_valid) begin
                stop_with_failure("Response valid dropped during the read burst");
            end
            check_response(response, expected_byte,
                           $sformatf("response_o (pixel %0d channel %0d)", k / 3, k % 3));
            operand_valid = 1'b0;
        end
        @(negedge clock_spi_in);
        op_code_valid = 1'b0;
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clock_spi_in);
            if (response_valid) begin
                stop_with_failure("Response valid went high with no opcode");
            end
        end
    endtask

    task automatic idle_status_test();
        expect_quiet(8);
        expect_status(8'h00); // Nothing captured yet
        expect_quiet(8);
    endtask

    task automatic frame_meter_test();
        meter_t measured;
        build_frame();
        send_frame();
        read_meter(measured);
        check_meter(measured, model_meter, "meter_o (first frame)");
    endtask

    task automatic capture_between_frames_test();
        response_t value;
        issue_command(OP_CAPTURE, 2'd0, value);
        build_frame();
        send_frame();
        expect_status(8'h01);
        read_bytes(3 * `CAM_RGB_PIXELS);
    endtask

    task automatic capture_mid_frame_test();
        response_t value;
        meter_t    measured;
        build_frame();
        fork
            send_frame();
            begin
                repeat (200) @(negedge clock_spi_in); // Well inside the frame
                issue_command(OP_CAPTURE, 2'd0, value);
            end
        join
        expect_status(8'h00); // Interrupted frame is skipped
        build_frame();
        fork
            send_frame();
            begin
                repeat (440) @(negedge clock_spi_in); // Last pixel written, frame still open
                expect_status(8'h00);
            end
        join
        expect_status(8'h01);
        read_bytes(3 * `CAM_RGB_PIXELS);
        read_meter(measured);
        check_meter(measured, model_meter, "meter_o (frame after mid-frame capture)");
    endtask

    task automatic second_capture_test();
        response_t value;
        meter_t    measured;
        read_bytes(5); // Leave the pointer mid-pixel
        issue_command(OP_CAPTURE, 2'd0, value);
        build_frame();
        send_frame();
        expect_status(8'h01);
        read_bytes(3 * `CAM_RGB_PIXELS);
        read_meter(measured);
        check_meter(measured, model_meter, "meter_o (latest frame)");
    endtask

    initial begin
        raw_pixel     = '0;
        op_code       = OP_STATUS;
        op_code_valid = 1'b0;
        operand_valid = 1'b0;
        operand_count = 2'd0;
        lfsr_state    = 32'hd801;
        @(posedge mipi_byte_reset_n);

        idle_status_test();
        frame_meter_test();
        capture_between_frames_test();
        capture_mid_frame_test();
        second_capture_test();

        @(negedge clock_spi_in);
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== bench/clock_gen.sv ====
// Testbench clock and reset source
// 4 ns clock, reset held low for the first two cycles
`timescale 1ns/1ps

module clock_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic clock_o,
    output logic reset_n_o
);

    initial begin
        clock_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clock_o = ~clock_o;
    end

    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock_o);
        @(negedge clock_o); // Release away from the active edge
        reset_n_o = 1'b1;
    end

endmodule

// ==== logic/camera_top.sv ====
// Camera front end top level
// Crop, demosaic, metering and capture path behind the command decoder
`timescale 1ns/1ps
`include "camera_defines.svh"

module camera_top (
    input  logic                   clock_spi_in,
    input  logic                   mipi_byte_reset_n,
    input  pixel_pkg::raw_pixel_t  raw_pixel_i,
    input  command_pkg::opcode_e   op_code_i,
    input  logic                   op_code_valid_i,
    input  logic                   operand_valid_i,
    input  logic [1:0]             operand_count_i,
    output command_pkg::response_t response_o,
    output logic                   response_valid_o
);

    import pixel_pkg::*;

    raw_pixel_t                cropped;
    rgb_beat_t                 beat;
    meter_t                    meter;
    rgb_pixel_t                write_data;
    rgb_pixel_t                read_data;
    logic                      write_enable;
    logic [`CAM_ADDR_BITS-1:0] write_address;
    logic [`CAM_ADDR_BITS-1:0] read_address;
    logic                      capture;
    logic                      capture_done;

    frame_crop frame_crop (
        .clock_spi_in, .mipi_byte_reset_n, .raw_i(raw_pixel_i), .raw_o(cropped)
    );

    bayer_demosaic bayer_demosaic (
        .clock_spi_in, .mipi_byte_reset_n, .raw_i(cropped), .beat_o(beat)
    );

    exposure_meter exposure_meter (
        .clock_spi_in, .mipi_byte_reset_n, .beat_i(beat), .meter_o(meter)
    );

    capture_writer capture_writer (
        .clock_spi_in,
        .mipi_byte_reset_n,
        .capture_i       (capture),
        .beat_i          (beat),
        .write_enable_o  (write_enable),
        .write_address_o (write_address),
        .write_data_o    (write_data),
        .done_o          (capture_done)
    );

    image_buffer image_buffer (
        .clock_spi_in,
        .write_enable_i  (write_enable),
        .write_address_i (write_address),
        .write_data_i    (write_data),
        .read_address_i  (read_address),
        .read_data_o     (read_data)
    );

    command_decoder command_decoder (
        .clock_spi_in,
        .mipi_byte_reset_n,
        .op_code_i,
        .op_code_valid_i,
        .operand_valid_i,
        .operand_count_i,
        .meter_i          (meter),
        .done_i           (capture_done),
        .read_data_i      (read_data),
        .read_address_o   (read_address),
        .capture_o        (capture),
        .response_o,
        .response_valid_o
    );

endmodule

// ==== logic/command_decoder.sv ====
// Opcode decoder for capture, status, readback and metering
// One registered response byte per opcode cycle
`timescale 1ns/1ps
`include "camera_defines.svh"

module command_decoder (
    input  logic                      clock_spi_in,
    input  logic                      mipi_byte_reset_n,
    input  command_pkg::opcode_e      op_code_i,
    input  logic                      op_code_valid_i,
    input  logic                      operand_valid_i,
    input  logic [1:0]                operand_count_i,
    input  pixel_pkg::meter_t         meter_i,
    input  logic                      done_i,
    input  pixel_pkg::rgb_pixel_t     read_data_i,
    output logic [`CAM_ADDR_BITS-1:0] read_address_o,
    output logic                      capture_o,
    output command_pkg::response_t    response_o,
    output logic                      response_valid_o
);

    import command_pkg::*;

    logic [`CAM_ADDR_BITS-1:0] pixel_index;
    logic [1:0]                channel;          // 0 red, 1 green, 2 blue
    logic                      operand_valid_q;
    logic                      op_code_valid_q;  // First cycle of an opcode
    logic                      operand_rise;
    response_t                 channel_byte;

    assign read_address_o = pixel_index;
    assign operand_rise   = operand_valid_i && !operand_valid_q;

    always_comb begin
        case (channel)
            2'd0:    channel_byte = read_data_i.red;
            2'd1:    channel_byte = read_data_i.green;
            default: channel_byte = read_data_i.blue;
        endcase
    end

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            pixel_index      <= '0;
            channel          <= '0;
            operand_valid_q  <= 1'b0;
            op_code_valid_q  <= 1'b0;
            capture_o        <= 1'b0;
            response_o       <= '0;
            response_valid_o <= 1'b0;
        end else begin
            operand_valid_q  <= operand_valid_i;
            op_code_valid_q  <= op_code_valid_i;
            capture_o        <= 1'b0;
            response_valid_o <= 1'b0;

            if (op_code_valid_i) begin
                case (op_code_i)
                    OP_CAPTURE: begin
                        capture_o        <= !op_code_valid_q;
                        pixel_index      <= '0;
                        channel          <= '0;
                        response_o       <= '0;
                        response_valid_o <= 1'b1;
                    end
                    OP_STATUS: begin
                        response_o       <= {7'd0, done_i};
                        response_valid_o <= 1'b1;
                    end
                    OP_READ: begin
                        response_o       <= channel_byte;
                        response_valid_o <= 1'b1;
                        if (operand_rise && channel == 2'd2) begin
                            channel     <= '0;
                            pixel_index <= pixel_index + 1'b1;
                        end else if (operand_rise) begin
                            channel <= channel + 1'b1;
                        end
                    end
                    OP_METER: begin
                        case (operand_count_i)
                            2'd0:    response_o <= meter_i.red;
                            2'd1:    response_o <= meter_i.green;
                            default: response_o <= meter_i.blue;
                        endcase
                        response_valid_o <= 1'b1;
                    end
                    default: response_valid_o <= 1'b0; // Unknown opcode stays silent
                endcase
            end
        end
    end

endmodule

// ==== logic/image_buffer.sv ====
// Captured frame memory, one RGB word per pixel
// Write on the clock edge, read straight from the address
`timescale 1ns/1ps
`include "camera_defines.svh"

module image_buffer (
    input  logic                      clock_spi_in,
    input  logic                      write_enable_i,
    input  logic [`CAM_ADDR_BITS-1:0] write_address_i,
    input  pixel_pkg::rgb_pixel_t     write_data_i,
    input  logic [`CAM_ADDR_BITS-1:0] read_address_i,
    output pixel_pkg::rgb_pixel_t     read_data_o
);

    import pixel_pkg::*;

    rgb_pixel_t memory [`CAM_RGB_PIXELS];

    always_ff @(posedge clock_spi_in) begin
        if (write_enable_i) begin
            memory[write_address_i] <= write_data_i;
        end
    end

    assign read_data_o = memory[read_address_i]; // Decoder samples in the same cycle

endmodule

// ==== logic/capture_writer.sv ====
// Single frame capture into the image buffer
// Arms on request, waits for a clean frame start, then stores every pixel
`timescale 1ns/1ps
`include "camera_defines.svh"

module capture_writer (
    input  logic                      clock_spi_in,
    input  logic                      mipi_byte_reset_n,
    input  logic                      capture_i,
    input  pixel_pkg::rgb_beat_t      beat_i,
    output logic                      write_enable_o,
    output logic [`CAM_ADDR_BITS-1:0] write_address_o,
    output pixel_pkg::rgb_pixel_t     write_data_o,
    output logic                      done_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ARMED,      // Frame in flight, let it pass
        ST_WAIT_START,
        ST_WRITING
    } state_e;

    state_e              state;
    logic [`CAM_ADDR_BITS:0] address_count; // Extra bit stops writes past the end

    assign write_enable_o  = (state == ST_WRITING) && beat_i.pixel_valid &&
                             (address_count < `CAM_RGB_PIXELS);
    assign write_address_o = address_count[`CAM_ADDR_BITS-1:0];
    assign write_data_o    = beat_i.pixel;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state         <= ST_IDLE;
            address_count <= '0;
            done_o        <= 1'b0;
        end else if (capture_i) begin
            done_o        <= 1'b0;
            address_count <= '0;
            state         <= beat_i.frame_valid ? ST_ARMED : ST_WAIT_START;
        end else begin
            case (state)
                ST_ARMED: begin
                    if (!beat_i.frame_valid) begin
                        state <= ST_WAIT_START;
                    end
                end
                ST_WAIT_START: begin
                    if (beat_i.frame_valid) begin
                        state <= ST_WRITING;
                    end
                end
                ST_WRITING: begin
                    if (write_enable_o) begin
                        address_count <= address_count + 1'b1;
                    end
                    if (!beat_i.frame_valid) begin
                        state  <= ST_IDLE;
                        done_o <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== logic/exposure_meter.sv ====
// Per frame channel averages for exposure control
// Results hold until the next frame ends
`timescale 1ns/1ps
`include "camera_defines.svh"

module exposure_meter (
    input  logic                 clock_spi_in,
    input  logic                 mipi_byte_reset_n,
    input  pixel_pkg::rgb_beat_t beat_i,
    output pixel_pkg::meter_t    meter_o
);

    localparam int SUM_BITS = 8 + `CAM_METER_SHIFT; // No overflow over one frame

    logic [SUM_BITS-1:0] red_sum;
    logic [SUM_BITS-1:0] green_sum;
    logic [SUM_BITS-1:0] blue_sum;
    logic                frame_valid_q;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            red_sum       <= '0;
            green_sum     <= '0;
            blue_sum      <= '0;
            frame_valid_q <= 1'b0;
            meter_o       <= '0;
        end else begin
            frame_valid_q <= beat_i.frame_valid;

            if (beat_i.frame_valid && !frame_valid_q) begin
                red_sum   <= '0;
                green_sum <= '0;
                blue_sum  <= '0;
            end else if (beat_i.pixel_valid) begin
                red_sum   <= red_sum + beat_i.pixel.red;
                green_sum <= green_sum + beat_i.pixel.green;
                blue_sum  <= blue_sum + beat_i.pixel.blue;
            end

            // Frame end, sum over pixel count
            if (frame_valid_q && !beat_i.frame_valid) begin
                meter_o.red   <= red_sum[SUM_BITS-1 -: 8];
                meter_o.green <= green_sum[SUM_BITS-1 -: 8];
                meter_o.blue  <= blue_sum[SUM_BITS-1 -: 8];
            end
        end
    end

endmodule

// ==== logic/bayer_demosaic.sv ====
// RGGB demosaic, one RGB pixel per 2x2 cell
// Even rows go to a line buffer, the odd row completes each cell
`timescale 1ns/1ps
`include "camera_defines.svh"

module bayer_demosaic (
    input  logic                  clock_spi_in,
    input  logic                  mipi_byte_reset_n,
    input  pixel_pkg::raw_pixel_t raw_i,
    output pixel_pkg::rgb_beat_t  beat_o
);

    localparam int COL_BITS = $clog2(`CAM_CROP_WIDTH);

    logic [`CAM_PIXEL_BITS-1:0] line_buffer [`CAM_CROP_WIDTH]; // R and G interleaved
    logic [`CAM_PIXEL_BITS-1:0] green_hold; // Bottom-left green of the cell
    logic [`CAM_PIXEL_BITS-1:0] top_red;
    logic [`CAM_PIXEL_BITS-1:0] top_green;
    logic [`CAM_PIXEL_BITS:0]   green_sum;
    logic [COL_BITS-1:0]        column;
    logic                       odd_row;
    logic                       line_valid_q;
    logic                       pixel_valid_r;
    logic                       frame_valid_r;
    logic [7:0]                 red_r;
    logic [7:0]                 green_r;
    logic [7:0]                 blue_r;

    assign top_red   = line_buffer[{column[COL_BITS-1:1], 1'b0}];
    assign top_green = line_buffer[column];
    assign green_sum = top_green + green_hold; // Carry kept before halving

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            column        <= '0;
            odd_row       <= 1'b0;
            line_valid_q  <= 1'b0;
            pixel_valid_r <= 1'b0;
            frame_valid_r <= 1'b0;
        end else begin
            line_valid_q  <= raw_i.line_valid;
            frame_valid_r <= raw_i.frame_valid;
            pixel_valid_r <= raw_i.line_valid && odd_row && column[0]; // Blue closes the cell

            if (raw_i.line_valid) begin
                column <= column + 1'b1;
            end else begin
                column <= '0;
            end

            if (!raw_i.frame_valid) begin
                odd_row <= 1'b0;
            end else if (line_valid_q && !raw_i.line_valid) begin
                odd_row <= ~odd_row;
            end
        end
    end

    always_ff @(posedge clock_spi_in) begin
        if (raw_i.line_valid && !odd_row) begin
            line_buffer[column] <= raw_i.sample;
        end
        if (raw_i.line_valid && odd_row && !column[0]) begin
            green_hold <= raw_i.sample;
        end
        // Keep the top 8 bits of each channel
        if (raw_i.line_valid && odd_row && column[0]) begin
            red_r   <= top_red[`CAM_PIXEL_BITS-1 -: 8];
            green_r <= green_sum[`CAM_PIXEL_BITS -: 8];
            blue_r  <= raw_i.sample[`CAM_PIXEL_BITS-1 -: 8];
        end
    end

    assign beat_o.pixel_valid = pixel_valid_r;
    assign beat_o.frame_valid = frame_valid_r;
    assign beat_o.pixel.red   = red_r;
    assign beat_o.pixel.green = green_r;
    assign beat_o.pixel.blue  = blue_r;

endmodule

// ==== logic/frame_crop.sv ====
// Fixed window crop on the raw Bayer stream
// Samples outside the window lose line valid, one cycle latency
`timescale 1ns/1ps
`include "camera_defines.svh"

module frame_crop (
    input  logic                  clock_spi_in,
    input  logic                  mipi_byte_reset_n,
    input  pixel_pkg::raw_pixel_t raw_i,
    output pixel_pkg::raw_pixel_t raw_o
);

    localparam int X_END = `CAM_CROP_X_START + `CAM_CROP_WIDTH;
    localparam int Y_END = `CAM_CROP_Y_START + `CAM_CROP_HEIGHT;

    logic [10:0]                column_count;
    logic [9:0]                 row_count;
    logic                       line_valid_q; // Line end detect
    logic                       in_window;
    logic                       frame_valid_r;
    logic                       line_valid_r;
    logic [`CAM_PIXEL_BITS-1:0] sample_r;

    assign in_window = (column_count >= `CAM_CROP_X_START) && (column_count < X_END) &&
                       (row_count >= `CAM_CROP_Y_START) && (row_count < Y_END);

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            column_count  <= '0;
            row_count     <= '0;
            line_valid_q  <= 1'b0;
            frame_valid_r <= 1'b0;
            line_valid_r  <= 1'b0;
        end else begin
            line_valid_q  <= raw_i.line_valid;
            frame_valid_r <= raw_i.frame_valid;
            line_valid_r  <= raw_i.line_valid && in_window;

            if (raw_i.line_valid) begin
                column_count <= column_count + 1'b1;
            end else begin
                column_count <= '0;
            end

            // Rows count line ends, restart with each frame
            if (!raw_i.frame_valid) begin
                row_count <= '0;
            end else if (line_valid_q && !raw_i.line_valid) begin
                row_count <= row_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock_spi_in) begin
        sample_r <= raw_i.sample;
    end

    assign raw_o.frame_valid = frame_valid_r;
    assign raw_o.line_valid  = line_valid_r;
    assign raw_o.sample      = sample_r;

endmodule

// ==== logic/command_pkg.sv ====
// Command interface types
// Opcodes seen by the decoder and the byte it answers with
package command_pkg;

    typedef enum logic [7:0] {
        OP_CAPTURE = 8'h20, // Grab the next whole frame
        OP_STATUS  = 8'h21, // Capture done flag
        OP_READ    = 8'h22, // Stream R, G, B of each captured pixel
        OP_METER   = 8'h25  // Channel averages
    } opcode_e;

    typedef logic [7:0] response_t;

endpackage

// ==== logic/pixel_pkg.sv ====
// Pixel stream types
// Raw Bayer input, demosaiced RGB beats and exposure averages
`include "camera_defines.svh"

package pixel_pkg;

    typedef struct packed {
        logic                       frame_valid;
        logic                       line_valid;
        logic [`CAM_PIXEL_BITS-1:0] sample;
    } raw_pixel_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_pixel_t;

    // Demosaic output, one strobe per 2x2 cell
    typedef struct packed {
        logic       pixel_valid;
        logic       frame_valid;
        rgb_pixel_t pixel;
    } rgb_beat_t;

    typedef struct packed {
        logic [7:0] red;   // Frame average per channel
        logic [7:0] green;
        logic [7:0] blue;
    } meter_t;

endpackage

// ==== include/camera_defines.svh ====
// Camera front end sizing
// Sensor crop window, capture buffer depth and metering shift
`ifndef CAMERA_DEFINES_SVH
`define CAMERA_DEFINES_SVH

`define CAM_PIXEL_BITS   10 // Raw Bayer sample width

`define CAM_CROP_X_START 2  // First kept column
`define CAM_CROP_Y_START 2  // First kept row
`define CAM_CROP_WIDTH   16 // Must stay even for whole 2x2 cells
`define CAM_CROP_HEIGHT  16

// One RGB pixel per 2x2 cell
`define CAM_RGB_PIXELS   64
`define CAM_ADDR_BITS    6
`define CAM_METER_SHIFT  6  // log2 of CAM_RGB_PIXELS

`endif
